//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // core widths
  localparam int XLEN     = 32;
  localparam int REG_SEL  = 5;
  localparam int NUM_REGS = 32;

  // major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_AUIPC  = 7'b0010111,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // alu operations, compares last
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_SEQ,
    ALU_SNE,
    ALU_SGE,
    ALU_SGEU
  } alu_op_e;

  // reservation station classes
  typedef enum logic [2:0] {
    RS_ENT_ALU,
    RS_ENT_LDST,
    RS_ENT_BRANCH,
    RS_ENT_JAL,
    RS_ENT_JALR,
    RS_ENT_MUL,
    RS_ENT_DIV
  } rs_ent_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_type_e;

  // operand a and b sources
  typedef enum logic [1:0] {
    SRC_A_RS1,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_sel_e;

  typedef enum logic [1:0] {
    SRC_B_RS2,
    SRC_B_IMM,
    SRC_B_FOUR
  } src_b_sel_e;

  // multiply/divide request
  typedef enum logic [1:0] {
    MD_OP_MUL,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  typedef enum logic [1:0] {
    MD_OUT_LO,
    MD_OUT_HI,
    MD_OUT_REM
  } md_out_sel_e;

endpackage

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen
  import decode_pkg::*;
(
  input  logic [XLEN-1:0] inst_i,
  input  imm_type_e       imm_type_i,
  output logic [XLEN-1:0] imm_o
);

  logic sign;

  // every format takes its sign from bit 31
  assign sign = inst_i[31];

  always_comb begin
    case (imm_type_i)
      IMM_I: imm_o = {{20{sign}}, inst_i[31:20]};
      IMM_S: imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
      IMM_B: begin
        imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      end
      IMM_U: imm_o = {inst_i[31:12], 12'b0};
      IMM_J: begin
        imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      end
      default: imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv32_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_decoder
  import decode_pkg::*;
(
  input  logic [XLEN-1:0]    inst_i,
  output imm_type_e          imm_type_o,
  output logic [REG_SEL-1:0] rs1_o,
  output logic [REG_SEL-1:0] rs2_o,
  output logic [REG_SEL-1:0] rd_o,
  output src_a_sel_e         src_a_sel_o,
  output src_b_sel_e         src_b_sel_o,
  output logic               wr_reg_o,
  output logic               uses_rs1_o,
  output logic               uses_rs2_o,
  output logic               illegal_o,
  output alu_op_e            alu_op_o,
  output rs_ent_e            rs_ent_o,
  output logic [2:0]         dmem_size_o,
  output logic [2:0]         dmem_type_o,
  output md_op_e             md_op_o,
  output logic               md_in_1_signed_o,
  output logic               md_in_2_signed_o,
  output md_out_sel_e        md_out_sel_o
);

  // arithmetic funct3
  localparam logic [2:0] F3_ADD_SUB = 3'd0;
  localparam logic [2:0] F3_SLL     = 3'd1;
  localparam logic [2:0] F3_SLT     = 3'd2;
  localparam logic [2:0] F3_SLTU    = 3'd3;
  localparam logic [2:0] F3_XOR     = 3'd4;
  localparam logic [2:0] F3_SRL_SRA = 3'd5;
  localparam logic [2:0] F3_OR      = 3'd6;
  localparam logic [2:0] F3_AND     = 3'd7;
  // branch funct3, 2 and 3 are reserved
  localparam logic [2:0] F3_BEQ     = 3'd0;
  localparam logic [2:0] F3_BNE     = 3'd1;
  localparam logic [2:0] F3_BLT     = 3'd4;
  localparam logic [2:0] F3_BGE     = 3'd5;
  localparam logic [2:0] F3_BLTU    = 3'd6;
  localparam logic [2:0] F3_BGEU    = 3'd7;
  // M extension funct3
  localparam logic [2:0] F3_MUL     = 3'd0;
  localparam logic [2:0] F3_MULH    = 3'd1;
  localparam logic [2:0] F3_MULHSU  = 3'd2;
  localparam logic [2:0] F3_MULHU   = 3'd3;
  localparam logic [2:0] F3_DIV     = 3'd4;
  localparam logic [2:0] F3_DIVU    = 3'd5;
  localparam logic [2:0] F3_REM     = 3'd6;
  localparam logic [2:0] F3_REMU    = 3'd7;
  localparam logic [6:0] F7_MUL_DIV = 7'b0000001;

  opcode_e    opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       is_md;
  alu_op_e    alu_op_arith;
  rs_ent_e    rs_ent_md;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct7 = inst_i[31:25];
  assign funct3 = inst_i[14:12];
  assign is_md  = (opcode == OPC_OP) && (funct7 == F7_MUL_DIV);

  assign rd_o  = inst_i[11:7];
  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];

  // size in the low two bits, bit 2 flags unsigned loads
  assign dmem_size_o = {1'b0, funct3[1:0]};
  assign dmem_type_o = funct3;

  always_comb begin
    imm_type_o  = IMM_I;
    src_a_sel_o = SRC_A_RS1;
    src_b_sel_o = SRC_B_IMM;
    wr_reg_o    = 1'b0;
    uses_rs1_o  = 1'b1;
    uses_rs2_o  = 1'b0;
    illegal_o   = 1'b0;
    rs_ent_o    = RS_ENT_ALU;
    alu_op_o    = ALU_ADD;
    case (opcode)
      OPC_LOAD: begin
        wr_reg_o = 1'b1;
        rs_ent_o = RS_ENT_LDST;
      end
      OPC_STORE: begin
        uses_rs2_o = 1'b1;
        imm_type_o = IMM_S;
        rs_ent_o   = RS_ENT_LDST;
      end
      OPC_BRANCH: begin
        uses_rs2_o  = 1'b1;
        imm_type_o  = IMM_B;
        src_b_sel_o = SRC_B_RS2;
        rs_ent_o    = RS_ENT_BRANCH;
        case (funct3)
          F3_BEQ:  alu_op_o = ALU_SEQ;
          F3_BNE:  alu_op_o = ALU_SNE;
          F3_BLT:  alu_op_o = ALU_SLT;
          F3_BGE:  alu_op_o = ALU_SGE;
          F3_BLTU: alu_op_o = ALU_SLTU;
          F3_BGEU: alu_op_o = ALU_SGEU;
          default: illegal_o = 1'b1;
        endcase
      end
      OPC_JAL: begin
        uses_rs1_o  = 1'b0;
        imm_type_o  = IMM_J;
        src_a_sel_o = SRC_A_PC;
        src_b_sel_o = SRC_B_FOUR;
        wr_reg_o    = 1'b1;
        rs_ent_o    = RS_ENT_JAL;
      end
      OPC_JALR: begin
        illegal_o   = (funct3 != 3'd0);
        src_a_sel_o = SRC_A_PC;
        src_b_sel_o = SRC_B_FOUR;
        wr_reg_o    = 1'b1;
        rs_ent_o    = RS_ENT_JALR;
      end
      OPC_OP_IMM: begin
        alu_op_o = alu_op_arith;
        wr_reg_o = 1'b1;
      end
      OPC_OP: begin
        uses_rs2_o  = 1'b1;
        src_b_sel_o = SRC_B_RS2;
        alu_op_o    = alu_op_arith;
        wr_reg_o    = 1'b1;
        if (is_md) begin
          rs_ent_o = rs_ent_md;
        end
      end
      OPC_AUIPC: begin
        uses_rs1_o  = 1'b0;
        src_a_sel_o = SRC_A_PC;
        imm_type_o  = IMM_U;
        wr_reg_o    = 1'b1;
      end
      OPC_LUI: begin
        uses_rs1_o  = 1'b0;
        src_a_sel_o = SRC_A_ZERO;
        imm_type_o  = IMM_U;
        wr_reg_o    = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase
  end

  // shared funct3 table for OP and OP_IMM
  always_comb begin
    case (funct3)
      F3_ADD_SUB: begin
        // immediate forms have no subtract
        alu_op_arith = ((opcode == OPC_OP) && funct7[5]) ? ALU_SUB : ALU_ADD;
      end
      F3_SLL:     alu_op_arith = ALU_SLL;
      F3_SLT:     alu_op_arith = ALU_SLT;
      F3_SLTU:    alu_op_arith = ALU_SLTU;
      F3_XOR:     alu_op_arith = ALU_XOR;
      F3_SRL_SRA: alu_op_arith = funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_arith = ALU_OR;
      F3_AND:     alu_op_arith = ALU_AND;
      default:    alu_op_arith = ALU_ADD;
    endcase
  end

  // multiply/divide request, idle values unless M extension
  always_comb begin
    md_op_o          = MD_OP_MUL;
    md_in_1_signed_o = 1'b0;
    md_in_2_signed_o = 1'b0;
    md_out_sel_o     = MD_OUT_LO;
    rs_ent_md        = RS_ENT_MUL;
    if (is_md) begin
      case (funct3)
        F3_MUL: begin
          md_in_1_signed_o = 1'b1;
          md_in_2_signed_o = 1'b1;
        end
        F3_MULH: begin
          md_in_1_signed_o = 1'b1;
          md_in_2_signed_o = 1'b1;
          md_out_sel_o     = MD_OUT_HI;
        end
        F3_MULHSU: begin
          md_in_1_signed_o = 1'b1;
          md_out_sel_o     = MD_OUT_HI;
        end
        F3_MULHU: md_out_sel_o = MD_OUT_HI;
        F3_DIV: begin
          md_op_o          = MD_OP_DIV;
          md_in_1_signed_o = 1'b1;
          md_in_2_signed_o = 1'b1;
          rs_ent_md        = RS_ENT_DIV;
        end
        F3_DIVU: begin
          md_op_o   = MD_OP_DIV;
          rs_ent_md = RS_ENT_DIV;
        end
        F3_REM: begin
          md_op_o          = MD_OP_REM;
          md_in_1_signed_o = 1'b1;
          md_in_2_signed_o = 1'b1;
          md_out_sel_o     = MD_OUT_REM;
          rs_ent_md        = RS_ENT_DIV;
        end
        F3_REMU: begin
          md_op_o      = MD_OP_REM;
          md_out_sel_o = MD_OUT_REM;
          rs_ent_md    = RS_ENT_DIV;
        end
        default: md_op_o = MD_OP_MUL;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/reg_status.sv
`timescale 1ns/1ns
`default_nettype none

module reg_status
  import decode_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               inst_valid_i,
  input  logic [REG_SEL-1:0] rs1_i,
  input  logic [REG_SEL-1:0] rs2_i,
  input  logic [REG_SEL-1:0] rd_i,
  input  logic               uses_rs1_i,
  input  logic               uses_rs2_i,
  input  logic               wr_reg_i,
  input  logic               illegal_i,
  input  logic               wb_valid_i,
  input  logic [REG_SEL-1:0] wb_rd_i,
  output logic               rs1_busy_o,
  output logic               rs2_busy_o
);

  logic [NUM_REGS-1:0] busy_q;
  logic                set_en;
  logic                clr_en;

  // x0 is hardwired, so it never waits on a writer
  assign set_en = inst_valid_i && !illegal_i && wr_reg_i && (rd_i != '0);
  assign clr_en = wb_valid_i && (wb_rd_i != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
    end else begin
      if (clr_en) begin
        busy_q[wb_rd_i] <= 1'b0;
      end
      // later assignment, so a new writer beats a retiring one
      if (set_en) begin
        busy_q[rd_i] <= 1'b1;
      end
    end
  end

  // lookup sees the table before this cycle's own update
  assign rs1_busy_o = uses_rs1_i && busy_q[rs1_i];
  assign rs2_busy_o = uses_rs2_i && busy_q[rs2_i];

endmodule

`default_nettype wire

//--- source/dispatch_reg.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_reg
  import decode_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               inst_valid_i,
  input  rs_ent_e            rs_ent_i,
  input  alu_op_e            alu_op_i,
  input  src_a_sel_e         src_a_sel_i,
  input  src_b_sel_e         src_b_sel_i,
  input  logic [XLEN-1:0]    imm_i,
  input  logic [REG_SEL-1:0] rs1_i,
  input  logic [REG_SEL-1:0] rs2_i,
  input  logic [REG_SEL-1:0] rd_i,
  input  logic               wr_reg_i,
  input  logic [2:0]         dmem_size_i,
  input  logic [2:0]         dmem_type_i,
  input  md_op_e             md_op_i,
  input  logic               md_in_1_signed_i,
  input  logic               md_in_2_signed_i,
  input  md_out_sel_e        md_out_sel_i,
  input  logic               rs1_busy_i,
  input  logic               rs2_busy_i,
  input  logic               illegal_i,
  output logic               dispatch_valid_o,
  output rs_ent_e            rs_ent_o,
  output alu_op_e            alu_op_o,
  output src_a_sel_e         src_a_sel_o,
  output src_b_sel_e         src_b_sel_o,
  output logic [XLEN-1:0]    imm_o,
  output logic [REG_SEL-1:0] rs1_o,
  output logic [REG_SEL-1:0] rs2_o,
  output logic [REG_SEL-1:0] rd_o,
  output logic               wr_reg_o,
  output logic [2:0]         dmem_size_o,
  output logic [2:0]         dmem_type_o,
  output md_op_e             md_op_o,
  output logic               md_in_1_signed_o,
  output logic               md_in_2_signed_o,
  output md_out_sel_e        md_out_sel_o,
  output logic               rs1_busy_o,
  output logic               rs2_busy_o,
  output logic               illegal_o
);

  // one cycle pulse per accepted instruction
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dispatch_valid_o <= 1'b0;
    end else begin
      dispatch_valid_o <= inst_valid_i;
    end
  end

  // payload holds between strobes
  always_ff @(posedge clk_i) begin
    if (inst_valid_i) begin
      rs_ent_o         <= rs_ent_i;
      alu_op_o         <= alu_op_i;
      src_a_sel_o      <= src_a_sel_i;
      src_b_sel_o      <= src_b_sel_i;
      imm_o            <= imm_i;
      rs1_o            <= rs1_i;
      rs2_o            <= rs2_i;
      rd_o             <= rd_i;
      wr_reg_o         <= wr_reg_i;
      dmem_size_o      <= dmem_size_i;
      dmem_type_o      <= dmem_type_i;
      md_op_o          <= md_op_i;
      md_in_1_signed_o <= md_in_1_signed_i;
      md_in_2_signed_o <= md_in_2_signed_i;
      md_out_sel_o     <= md_out_sel_i;
      rs1_busy_o       <= rs1_busy_i;
      rs2_busy_o       <= rs2_busy_i;
      illegal_o        <= illegal_i;
    end
  end

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit
  import decode_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               inst_valid_i,
  input  logic [XLEN-1:0]    inst_i,
  input  logic               wb_valid_i,
  input  logic [REG_SEL-1:0] wb_rd_i,
  output logic               dispatch_valid_o,
  output rs_ent_e            rs_ent_o,
  output alu_op_e            alu_op_o,
  output src_a_sel_e         src_a_sel_o,
  output src_b_sel_e         src_b_sel_o,
  output logic [XLEN-1:0]    imm_o,
  output logic [REG_SEL-1:0] rs1_o,
  output logic [REG_SEL-1:0] rs2_o,
  output logic [REG_SEL-1:0] rd_o,
  output logic               wr_reg_o,
  output logic [2:0]         dmem_size_o,
  output logic [2:0]         dmem_type_o,
  output md_op_e             md_op_o,
  output logic               md_in_1_signed_o,
  output logic               md_in_2_signed_o,
  output md_out_sel_e        md_out_sel_o,
  output logic               rs1_busy_o,
  output logic               rs2_busy_o,
  output logic               illegal_o
);

  // decode-side fields ahead of the dispatch register
  imm_type_e          dec_imm_type;
  logic [REG_SEL-1:0] dec_rs1, dec_rs2, dec_rd;
  src_a_sel_e         dec_src_a_sel;
  src_b_sel_e         dec_src_b_sel;
  logic               dec_wr_reg, dec_uses_rs1, dec_uses_rs2, dec_illegal;
  alu_op_e            dec_alu_op;
  rs_ent_e            dec_rs_ent;
  logic [2:0]         dec_dmem_size, dec_dmem_type;
  md_op_e             dec_md_op;
  logic               dec_md_in_1_signed, dec_md_in_2_signed;
  md_out_sel_e        dec_md_out_sel;
  logic [XLEN-1:0]    dec_imm;
  logic               dec_rs1_busy, dec_rs2_busy;

  rv32_decoder i_decoder (
    .inst_i           (inst_i),
    .imm_type_o       (dec_imm_type),
    .rs1_o            (dec_rs1),
    .rs2_o            (dec_rs2),
    .rd_o             (dec_rd),
    .src_a_sel_o      (dec_src_a_sel),
    .src_b_sel_o      (dec_src_b_sel),
    .wr_reg_o         (dec_wr_reg),
    .uses_rs1_o       (dec_uses_rs1),
    .uses_rs2_o       (dec_uses_rs2),
    .illegal_o        (dec_illegal),
    .alu_op_o         (dec_alu_op),
    .rs_ent_o         (dec_rs_ent),
    .dmem_size_o      (dec_dmem_size),
    .dmem_type_o      (dec_dmem_type),
    .md_op_o          (dec_md_op),
    .md_in_1_signed_o (dec_md_in_1_signed),
    .md_in_2_signed_o (dec_md_in_2_signed),
    .md_out_sel_o     (dec_md_out_sel)
  );

  imm_gen i_imm_gen (
    .inst_i     (inst_i),
    .imm_type_i (dec_imm_type),
    .imm_o      (dec_imm)
  );

  reg_status i_reg_status (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .rs1_i        (dec_rs1),
    .rs2_i        (dec_rs2),
    .rd_i         (dec_rd),
    .uses_rs1_i   (dec_uses_rs1),
    .uses_rs2_i   (dec_uses_rs2),
    .wr_reg_i     (dec_wr_reg),
    .illegal_i    (dec_illegal),
    .wb_valid_i   (wb_valid_i),
    .wb_rd_i      (wb_rd_i),
    .rs1_busy_o   (dec_rs1_busy),
    .rs2_busy_o   (dec_rs2_busy)
  );

  dispatch_reg i_dispatch_reg (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .inst_valid_i     (inst_valid_i),
    .rs_ent_i         (dec_rs_ent),
    .alu_op_i         (dec_alu_op),
    .src_a_sel_i      (dec_src_a_sel),
    .src_b_sel_i      (dec_src_b_sel),
    .imm_i            (dec_imm),
    .rs1_i            (dec_rs1),
    .rs2_i            (dec_rs2),
    .rd_i             (dec_rd),
    .wr_reg_i         (dec_wr_reg),
    .dmem_size_i      (dec_dmem_size),
    .dmem_type_i      (dec_dmem_type),
    .md_op_i          (dec_md_op),
    .md_in_1_signed_i (dec_md_in_1_signed),
    .md_in_2_signed_i (dec_md_in_2_signed),
    .md_out_sel_i     (dec_md_out_sel),
    .rs1_busy_i       (dec_rs1_busy),
    .rs2_busy_i       (dec_rs2_busy),
    .illegal_i        (dec_illegal),
    .dispatch_valid_o (dispatch_valid_o),
    .rs_ent_o         (rs_ent_o),
    .alu_op_o         (alu_op_o),
    .src_a_sel_o      (src_a_sel_o),
    .src_b_sel_o      (src_b_sel_o),
    .imm_o            (imm_o),
    .rs1_o            (rs1_o),
    .rs2_o            (rs2_o),
    .rd_o             (rd_o),
    .wr_reg_o         (wr_reg_o),
    .dmem_size_o      (dmem_size_o),
    .dmem_type_o      (dmem_type_o),
    .md_op_o          (md_op_o),
    .md_in_1_signed_o (md_in_1_signed_o),
    .md_in_2_signed_o (md_in_2_signed_o),
    .md_out_sel_o     (md_out_sel_o),
    .rs1_busy_o       (rs1_busy_o),
    .rs2_busy_o       (rs2_busy_o),
    .illegal_o        (illegal_o)
  );

endmodule

`default_nettype wire

//--- sim/decode_unit_props.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit_props (
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       inst_valid_i,
  input logic       dispatch_valid_i,
  input logic       uses_rs1_i,
  input logic       uses_rs2_i,
  input logic [4:0] rs1_i,
  input logic [4:0] rs2_i,
  input logic       rs1_busy_i,
  input logic       rs2_busy_i
);

  // dispatch pulse follows the strobe by one cycle
  a_dispatch_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    inst_valid_i |=> dispatch_valid_i) else $error("dispatch pulse missing");

  a_no_extra_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !inst_valid_i |=> !dispatch_valid_i) else $error("dispatch pulse without strobe");

  // busy only for a source the instruction reads
  a_busy_uses: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rs1_busy_i && !uses_rs1_i) && !(rs2_busy_i && !uses_rs2_i))
    else $error("busy on unused source");

  a_x0_free: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rs1_busy_i && rs1_i == 5'd0) && !(rs2_busy_i && rs2_i == 5'd0))
    else $error("x0 marked busy");

endmodule

bind decode_unit decode_unit_props i_props (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .inst_valid_i     (inst_valid_i),
  .dispatch_valid_i (dispatch_valid_o),
  .uses_rs1_i       (dec_uses_rs1),
  .uses_rs2_i       (dec_uses_rs2),
  .rs1_i            (dec_rs1),
  .rs2_i            (dec_rs2),
  .rs1_busy_i       (dec_rs1_busy),
  .rs2_busy_i       (dec_rs2_busy)
);

`default_nettype wire

//--- sim/decode_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit_tb
  import decode_pkg::*;
();

  typedef struct {
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    rs_ent_e     rs_ent;
    alu_op_e     alu_op;
    src_a_sel_e  src_a;
    src_b_sel_e  src_b;
    logic [31:0] imm;
    logic        wr_reg;
    logic        illegal;
    logic [2:0]  dmem_size;
    logic [2:0]  dmem_type;
    md_op_e      md_op;
    logic        md_s1;
    logic        md_s2;
    md_out_sel_e md_sel;
    logic        busy1;
    logic        busy2;
  } row_t;

  logic clk_i, arst_n_i, inst_valid_i, wb_valid_i;
  logic [31:0] inst_i;
  logic [4:0] wb_rd_i;
  logic dispatch_valid_o, wr_reg_o, md_in_1_signed_o, md_in_2_signed_o;
  logic rs1_busy_o, rs2_busy_o, illegal_o;
  rs_ent_e rs_ent_o;
  alu_op_e alu_op_o;
  src_a_sel_e src_a_sel_o;
  src_b_sel_e src_b_sel_o;
  logic [31:0] imm_o;
  logic [4:0] rs1_o, rs2_o, rd_o;
  logic [2:0] dmem_size_o, dmem_type_o;
  md_op_e md_op_o;
  md_out_sel_e md_out_sel_o;

  row_t rows[$];
  // busy bits the table expects while rows are built
  logic [31:0] model_busy;
  integer seed;

  decode_unit i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  task automatic add_row(logic [31:0] inst, logic wbv, logic [4:0] wbrd, rs_ent_e ent,
                         alu_op_e alu, src_a_sel_e sa, src_b_sel_e sb, logic [31:0] imm,
                         logic wr, logic ill, logic [2:0] dsz, logic [2:0] dty,
                         logic b1, logic b2);
    row_t r;
    r = '{inst, wbv, wbrd, ent, alu, sa, sb, imm, wr, ill, dsz, dty,
          MD_OP_MUL, 1'b0, 1'b0, MD_OUT_LO, b1, b2};
    rows.push_back(r);
    if (wbv && wbrd != 5'd0) model_busy[wbrd] = 1'b0;
    // a new writer wins over a writeback in the same cycle
    if (!ill && wr && inst[11:7] != 5'd0) model_busy[inst[11:7]] = 1'b1;
  endtask

  task automatic set_md(md_op_e op, logic s1, logic s2, md_out_sel_e sel);
    rows[rows.size()-1].md_op  = op;
    rows[rows.size()-1].md_s1  = s1;
    rows[rows.size()-1].md_s2  = s2;
    rows[rows.size()-1].md_sel = sel;
  endtask

  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    model_busy = '0;
    // alu decode
    add_row(enc_r(7'h00, 2, 1, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h2, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h20, 2, 1, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_SUB, SRC_A_RS1, SRC_B_RS2,
            32'h402, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h20, 2, 1, 5, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_SRA, SRC_A_RS1, SRC_B_RS2,
            32'h402, 1, 0, 1, 5, 0, 0);
    add_row(enc_r(7'h00, 2, 1, 5, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_SRL, SRC_A_RS1, SRC_B_RS2,
            32'h2, 1, 0, 1, 5, 0, 0);
    add_row(enc_r(7'h00, 2, 1, 3, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_SLTU, SRC_A_RS1, SRC_B_RS2,
            32'h2, 1, 0, 3, 3, 0, 0);
    add_row(enc_r(7'h00, 2, 1, 7, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_AND, SRC_A_RS1, SRC_B_RS2,
            32'h2, 1, 0, 3, 7, 0, 0);
    add_row(enc_i(12'hFFB, 1, 0, 0, OPC_OP_IMM), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'hFFFF_FFFB, 1, 0, 0, 0, 0, 0);
    // addi never subtracts
    add_row(enc_i(12'h400, 1, 0, 0, OPC_OP_IMM), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h400, 1, 0, 0, 0, 0, 0);
    // control flow and upper immediates
    add_row(enc_b(13'h1FF8, 2, 1, 0), 0, 0, RS_ENT_BRANCH, ALU_SEQ, SRC_A_RS1, SRC_B_RS2,
            32'hFFFF_FFF8, 0, 0, 0, 0, 0, 0);
    add_row(enc_b(13'h0010, 2, 1, 7), 0, 0, RS_ENT_BRANCH, ALU_SGEU, SRC_A_RS1, SRC_B_RS2,
            32'h10, 0, 0, 3, 7, 0, 0);
    add_row(enc_j(21'h800, 0), 0, 0, RS_ENT_JAL, ALU_ADD, SRC_A_PC, SRC_B_FOUR,
            32'h800, 1, 0, 0, 0, 0, 0);
    add_row(enc_i(12'h00C, 1, 0, 0, OPC_JALR), 0, 0, RS_ENT_JALR, ALU_ADD, SRC_A_PC, SRC_B_FOUR,
            32'hC, 1, 0, 0, 0, 0, 0);
    add_row({20'hABCDE, 5'd0, 7'h37}, 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_ZERO, SRC_B_IMM,
            32'hABCD_E000, 1, 0, 2, 6, 0, 0);
    add_row({20'h00012, 5'd0, 7'h17}, 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_PC, SRC_B_IMM,
            32'h0001_2000, 1, 0, 2, 2, 0, 0);
    // memory and multiply/divide
    add_row(enc_i(12'hFFC, 1, 2, 0, OPC_LOAD), 0, 0, RS_ENT_LDST, ALU_ADD, SRC_A_RS1, SRC_B_IMM,
            32'hFFFF_FFFC, 1, 0, 2, 2, 0, 0);
    add_row(enc_i(12'h008, 1, 4, 0, OPC_LOAD), 0, 0, RS_ENT_LDST, ALU_ADD, SRC_A_RS1, SRC_B_IMM,
            32'h8, 1, 0, 0, 4, 0, 0);
    add_row(enc_s(12'h006, 2, 1, 1), 0, 0, RS_ENT_LDST, ALU_ADD, SRC_A_RS1, SRC_B_IMM,
            32'h6, 0, 0, 1, 1, 0, 0);
    add_row(enc_r(7'h01, 2, 1, 1, 0, OPC_OP), 0, 0, RS_ENT_MUL, ALU_SLL, SRC_A_RS1, SRC_B_RS2,
            32'h22, 1, 0, 1, 1, 0, 0);
    set_md(MD_OP_MUL, 1, 1, MD_OUT_HI);
    add_row(enc_r(7'h01, 2, 1, 2, 0, OPC_OP), 0, 0, RS_ENT_MUL, ALU_SLT, SRC_A_RS1, SRC_B_RS2,
            32'h22, 1, 0, 2, 2, 0, 0);
    set_md(MD_OP_MUL, 1, 0, MD_OUT_HI);
    add_row(enc_r(7'h01, 2, 1, 5, 0, OPC_OP), 0, 0, RS_ENT_DIV, ALU_SRL, SRC_A_RS1, SRC_B_RS2,
            32'h22, 1, 0, 1, 5, 0, 0);
    set_md(MD_OP_DIV, 0, 0, MD_OUT_LO);
    add_row(enc_r(7'h01, 2, 1, 6, 0, OPC_OP), 0, 0, RS_ENT_DIV, ALU_OR, SRC_A_RS1, SRC_B_RS2,
            32'h22, 1, 0, 2, 6, 0, 0);
    set_md(MD_OP_REM, 1, 1, MD_OUT_REM);
    // illegal forms aimed at x7 and a later reader of x7
    add_row(enc_r(7'h00, 2, 1, 0, 7, 7'h7F), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_IMM,
            32'h2, 0, 1, 0, 0, 0, 0);
    add_row(enc_b(13'h0010, 2, 1, 2), 0, 0, RS_ENT_BRANCH, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h10, 0, 1, 2, 2, 0, 0);
    add_row(enc_i(12'h000, 1, 1, 7, OPC_JALR), 0, 0, RS_ENT_JALR, ALU_ADD, SRC_A_PC, SRC_B_FOUR,
            32'h0, 1, 1, 1, 1, 0, 0);
    add_row(enc_r(7'h00, 7, 7, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h7, 1, 0, 0, 0, 0, 0);
    // x5 written, read, retired, read again
    add_row(enc_i(12'h001, 1, 0, 5, OPC_OP_IMM), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h1, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 2, 5, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h2, 1, 0, 0, 0, 1, 0);
    add_row(enc_i(12'h000, 0, 0, 0, OPC_OP_IMM), 1, 5, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h0, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 5, 5, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h5, 1, 0, 0, 0, 0, 0);
    // writes to x0 are dropped
    add_row(enc_i(12'h003, 1, 0, 0, OPC_OP_IMM), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h3, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 0, 0, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h0, 1, 0, 0, 0, 0, 0);
    // set and clear of x6 in one cycle
    add_row(enc_i(12'h001, 1, 0, 6, OPC_OP_IMM), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h1, 1, 0, 0, 0, 0, 0);
    add_row(enc_i(12'h002, 1, 0, 6, OPC_OP_IMM), 1, 6, RS_ENT_ALU, ALU_ADD, SRC_A_RS1,
            SRC_B_IMM, 32'h2, 1, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 6, 6, 0, 0, OPC_OP), 0, 0, RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2,
            32'h6, 1, 0, 0, 0, 1, 1);
    // random addi and add words
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      if (r[28]) begin
        add_row(enc_i(r[26:15], r[9:5], 0, r[4:0], OPC_OP_IMM), r[27], {1'b0, r[31:28]},
                RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_IMM, {{20{r[26]}}, r[26:15]},
                1, 0, 0, 0, model_busy[r[9:5]], 0);
      end else begin
        add_row(enc_r(7'h00, r[14:10], r[9:5], 0, r[4:0], OPC_OP), r[27], {1'b0, r[31:28]},
                RS_ENT_ALU, ALU_ADD, SRC_A_RS1, SRC_B_RS2, {27'b0, r[14:10]},
                1, 0, 0, 0, model_busy[r[9:5]], model_busy[r[14:10]]);
      end
    end
  endtask

  task automatic check_row(row_t e);
    check_val("rs_ent_o", rs_ent_o, e.rs_ent);
    check_val("alu_op_o", alu_op_o, e.alu_op);
    check_val("src_a_sel_o", src_a_sel_o, e.src_a);
    check_val("src_b_sel_o", src_b_sel_o, e.src_b);
    check_val("imm_o", imm_o, e.imm);
    check_val("rs1_o", rs1_o, e.inst[19:15]);
    check_val("rs2_o", rs2_o, e.inst[24:20]);
    check_val("rd_o", rd_o, e.inst[11:7]);
    check_val("wr_reg_o", wr_reg_o, e.wr_reg);
    check_val("illegal_o", illegal_o, e.illegal);
    check_val("dmem_size_o", dmem_size_o, e.dmem_size);
    check_val("dmem_type_o", dmem_type_o, e.dmem_type);
    check_val("md_op_o", md_op_o, e.md_op);
    check_val("md_in_1_signed_o", md_in_1_signed_o, e.md_s1);
    check_val("md_in_2_signed_o", md_in_2_signed_o, e.md_s2);
    check_val("md_out_sel_o", md_out_sel_o, e.md_sel);
    check_val("rs1_busy_o", rs1_busy_o, e.busy1);
    check_val("rs2_busy_o", rs2_busy_o, e.busy2);
  endtask

  initial begin
    int waited;
    seed = 32'h4b467932;
    arst_n_i = 1'b0;
    // strobe stays high while reset holds the dispatch port low
    inst_valid_i = 1'b1;
    inst_i = '0;
    wb_valid_i = 1'b0;
    wb_rd_i = '0;
    build_table();
    repeat (8) begin
      @(posedge clk_i);
      #1;
      check_val("dispatch_valid_o", dispatch_valid_o, 0);
    end
    arst_n_i = 1'b1;
    // one row per cycle with back-to-back strobes
    foreach (rows[i]) begin
      inst_valid_i = 1'b1;
      inst_i = rows[i].inst;
      wb_valid_i = rows[i].wb_valid;
      wb_rd_i = rows[i].wb_rd;
      @(posedge clk_i);
      #1;
      waited = 0;
      while (!dispatch_valid_o) begin
        if (waited == 4) begin
          $display("timeout: no dispatch pulse for table row %0d", i);
          stop_with_failure();
        end
        @(posedge clk_i);
        #1;
        waited++;
      end
      if (waited != 0) begin
        $display("dispatch pulse for table row %0d came %0d cycles late", i, waited);
        stop_with_failure();
      end
      check_row(rows[i]);
    end
    inst_valid_i = 1'b0;
    wb_valid_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_val("dispatch_valid_o", dispatch_valid_o, 0);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- decode_unit.f
source/decode_pkg.sv
source/imm_gen.sv
source/rv32_decoder.sv
source/reg_status.sv
source/dispatch_reg.sv
source/decode_unit.sv
sim/decode_unit_props.sv
sim/decode_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_unit_tb -f decode_unit.f -o decode_unit_sim

out=$(./obj_dir/decode_unit_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1
